/* hdl/rvcDecPkg.sv */
// ##################
// rvcDecPkg
// shared types and encodings for the compressed-instruction decode stage
// ##################

package rvcDecPkg;

	// field widths
	localparam int instrW   = 16;
	localparam int gprW     = 7;
	localparam int immW     = 33;
	localparam int immRawW  = 12;
	localparam int nmidW    = 6;
	localparam int fmidW    = 5;
	localparam int ityW     = 4;
	localparam int btyW     = 3;
	localparam int ucIxW    = 6;
	localparam int immSelW  = 4;
	localparam int ccW      = 3;	// condition code and unit code share this width

	typedef logic [instrW-1:0]      instrT;
	typedef logic [gprW-1:0]        gprIdT;
	typedef logic [immW-1:0]        immT;
	typedef logic [immRawW-1:0]     immRawT;
	typedef logic [nmidW-1:0]       nmidT;
	typedef logic [fmidW-1:0]       fmidT;
	typedef logic [ityW-1:0]        ityT;
	typedef logic [btyW-1:0]        btyT;
	typedef logic [ucIxW-1:0]       ucIxT;
	typedef logic [immSelW-1:0]     immSelT;
	typedef logic [ccW+nmidW-1:0]   uCmdT;	// cc above nmid
	typedef logic [ccW+ucIxW-1:0]   uIxtT;	// unit above sub-index

	// special registers sit above the GPR and FPR ranges
	localparam gprIdT regZero = 7'h40;
	localparam gprIdT regLink = 7'h41;
	localparam gprIdT regSp   = 7'h42;
	localparam gprIdT regGbr  = 7'h43;
	localparam gprIdT regDlr  = 7'h44;
	localparam gprIdT regBpc  = 7'h45;
	localparam gprIdT regImm  = 7'h46;	// operand comes from the immediate

	localparam gprIdT r2  = 7'd2;
	localparam gprIdT r3  = 7'd3;
	localparam gprIdT r4  = 7'd4;
	localparam gprIdT r5  = 7'd5;
	localparam gprIdT r7  = 7'd7;
	localparam gprIdT r8  = 7'd8;
	localparam gprIdT r9  = 7'd9;
	localparam gprIdT r10 = 7'd10;
	localparam gprIdT r11 = 7'd11;
	localparam gprIdT r12 = 7'd12;
	localparam gprIdT r13 = 7'd13;

	localparam gprIdT fpBase = 7'd32;	// FP register n is fpBase + n

	// micro-ops
	localparam nmidT ucNop    = 6'h00;
	localparam nmidT ucMovRm  = 6'h01;
	localparam nmidT ucMovMr  = 6'h02;
	localparam nmidT ucMovIr  = 6'h03;
	localparam nmidT ucBra    = 6'h08;
	localparam nmidT ucJmp    = 6'h0A;
	localparam nmidT ucJsr    = 6'h0B;
	localparam nmidT ucJcmp   = 6'h0C;
	localparam nmidT ucAlu3   = 6'h10;
	localparam nmidT ucShad3  = 6'h12;
	localparam nmidT ucConvRr = 6'h14;
	localparam nmidT ucOpIxt  = 6'h20;
	localparam nmidT ucInvop  = 6'h3F;

	// operand formats
	localparam fmidT fmInv          = 5'd0;
	localparam fmidT fmZ            = 5'd1;
	localparam fmidT fmReg          = 5'd2;
	localparam fmidT fmRegReg       = 5'd3;
	localparam fmidT fmImm8Reg      = 5'd4;
	localparam fmidT fmLdRegDispReg = 5'd5;
	localparam fmidT fmLdDi4SpReg   = 5'd6;
	localparam fmidT fmRegPc        = 5'd7;
	localparam fmidT fmPcDisp8      = 5'd8;

	// per-format variants
	localparam ityT itySb = 4'd0;
	localparam ityT itySw = 4'd1;
	localparam ityT ityUb = 4'd2;
	localparam ityT ityUw = 4'd3;
	localparam ityT ityUl = 4'd4;
	localparam ityT ityNb = 4'd5;
	localparam ityT ityNw = 4'd6;

	localparam btyT btySl = 3'b010;	// 32-bit access
	localparam btyT btySq = 3'b011;	// 64-bit access

	// command sub-indices, meaning depends on nmid
	localparam ucIxT ucIxAluAdd     = 6'h00;
	localparam ucIxT ucIxAluSub     = 6'h01;
	localparam ucIxT ucIxAluAnd     = 6'h05;
	localparam ucIxT ucIxAluOr      = 6'h06;
	localparam ucIxT ucIxAluXor     = 6'h07;
	localparam ucIxT ucIxAluAddSl   = 6'h08;
	localparam ucIxT ucIxAluSubSl   = 6'h09;
	localparam ucIxT ucIxShadShldQ3 = 6'h01;
	localparam ucIxT ucIxShadShlrQ3 = 6'h02;
	localparam ucIxT ucIxShadSharQ3 = 6'h03;
	localparam ucIxT ucIxLdiLdix    = 6'h02;
	localparam ucIxT ucIxConvMov    = 6'h00;
	localparam ucIxT ucIxJcmpQeq    = 6'h00;
	localparam ucIxT ucIxJcmpQne    = 6'h01;
	localparam ucIxT ucIxIxtBreak   = 6'h08;
	localparam ucIxT ucIxBraFixed   = 6'b01_1_001;	// sub-index of every branch and jump

	// immediate layouts
	localparam immSelT isNone   = 4'd0;
	localparam immSelT isAlu6   = 4'd1;
	localparam immSelT isAlu6Z  = 4'd2;
	localparam immSelT isLw4    = 4'd3;
	localparam immSelT isQw4    = 4'd4;
	localparam immSelT isLwLd6  = 4'd5;
	localparam immSelT isQwLd6  = 4'd6;
	localparam immSelT isLwSt6  = 4'd7;
	localparam immSelT isQwSt6  = 4'd8;
	localparam immSelT isA16Sp  = 4'd9;
	localparam immSelT isLui6   = 4'd10;
	localparam immSelT isJ11    = 4'd11;
	localparam immSelT isJcc8   = 4'd12;
	localparam immSelT isSpn8   = 4'd13;

	localparam logic [ccW-1:0] ccAlways = 3'b000;
	localparam logic [ccW-1:0] ucScalar = 3'b000;

endpackage

/* hdl/rvcRegMap.sv */
// ##################
// rvcRegMap
// maps instruction register fields onto full register ids
// ##################

`timescale 1ns/1ps

module rvcRegMap (
	input  rvcDecPkg::instrT instr,
	output rvcDecPkg::gprIdT regMDfl,
	output rvcDecPkg::gprIdT regNDfl,
	output rvcDecPkg::gprIdT regMEr,
	output rvcDecPkg::gprIdT regNEr,
	output rvcDecPkg::gprIdT regMFr,
	output rvcDecPkg::gprIdT regMFpr,
	output rvcDecPkg::gprIdT regNFpr
);
	import rvcDecPkg::*;

	// lower 16 of the 5-bit space land on the core's fixed registers
	function automatic gprIdT lowMap(input logic [3:0] field);
		case (field)
			4'h0: lowMap = regZero;
			4'h1: lowMap = regLink;
			4'h2: lowMap = regSp;
			4'h3: lowMap = regGbr;
			4'h4: lowMap = r4;
			4'h5: lowMap = r5;
			4'h6: lowMap = regDlr;
			4'h7: lowMap = r7;
			4'h8: lowMap = r8;
			4'h9: lowMap = r9;
			4'hA: lowMap = r10;
			4'hB: lowMap = r11;
			4'hC: lowMap = r12;
			4'hD: lowMap = r13;
			4'hE: lowMap = r2;
			4'hF: lowMap = r3;
		endcase
	endfunction

	function automatic gprIdT dflMap(input logic [4:0] field);
		if (field[4])
			dflMap = {2'b00, field};	// upper half passes straight through
		else
			dflMap = lowMap(field[3:0]);
	endfunction

	// compressed fields name x8..x15 and so reuse the upper half of the table
	function automatic gprIdT erMap(input logic [2:0] field);
		erMap = lowMap({1'b1, field});
	endfunction

	assign regMDfl = dflMap(instr[6:2]);
	assign regNDfl = dflMap(instr[11:7]);
	assign regMEr  = erMap(instr[4:2]);
	assign regNEr  = erMap(instr[9:7]);

	assign regMFr  = fpBase + {4'b0001, instr[4:2]};	// f8..f15
	assign regMFpr = fpBase + {2'b00, instr[6:2]};
	assign regNFpr = fpBase + {2'b00, instr[11:7]};

endmodule

/* hdl/rvcImmGen.sv */
// ##################
// rvcImmGen
// unscrambles compressed immediates and sign-extends to 33 bits
// ##################

`timescale 1ns/1ps

module rvcImmGen (
	input  rvcDecPkg::instrT  instr,
	input  rvcDecPkg::immSelT immSel,
	output rvcDecPkg::immT    imm
);
	import rvcDecPkg::*;

	immRawT offsJ;
	immRawT offsBcc;
	immRawT alu6;
	immRawT alu6Z;
	immRawT a16Sp;
	immRawT spn8;
	immRawT lw4;
	immRawT qw4;
	immRawT lwLd6;
	immRawT qwLd6;
	immRawT lwSt6;
	immRawT qwSt6;
	immRawT immRaw;

	assign offsJ = {instr[12], instr[8], instr[10], instr[9], instr[6], instr[7],
		instr[2], instr[11], instr[5], instr[4], instr[3], 1'b0};
	assign offsBcc = {{4{instr[12]}}, instr[6:5], instr[2], instr[11:10],
		instr[4:3], 1'b0};

	assign alu6  = {{7{instr[12]}}, instr[6:2]};
	assign alu6Z = {6'h00, instr[12], instr[6:2]};	// shift amounts, never negative
	assign a16Sp = {{3{instr[12]}}, instr[4:3], instr[5], instr[2], instr[6], 4'h0};
	assign spn8  = {2'b00, instr[10:7], instr[12:11], instr[5], instr[6], 2'b00};

	// register-relative offsets
	assign lw4 = {5'b00000, instr[5], instr[12:10], instr[6], 2'b00};
	assign qw4 = {4'b0000, instr[6:5], instr[12:10], 3'b000};

	// sp-relative offsets
	assign lwLd6 = {4'b0000, instr[3:2], instr[12], instr[6:4], 2'b00};
	assign qwLd6 = {3'b000, instr[4], instr[3:2], instr[12], instr[6:5], 3'b000};
	assign lwSt6 = {4'b0000, instr[8:7], instr[12:9], 2'b00};
	assign qwSt6 = {3'b000, instr[9:7], instr[12:10], 3'b000};

	always_comb begin
		case (immSel)
			isAlu6:  immRaw = alu6;
			isAlu6Z: immRaw = alu6Z;
			isLw4:   immRaw = lw4;
			isQw4:   immRaw = qw4;
			isLwLd6: immRaw = lwLd6;
			isQwLd6: immRaw = qwLd6;
			isLwSt6: immRaw = lwSt6;
			isQwSt6: immRaw = qwSt6;
			isA16Sp: immRaw = a16Sp;
			isLui6:  immRaw = alu6;
			isJ11:   immRaw = {offsJ[11], offsJ[11:1]};	// halved, in 16-bit units
			isJcc8:  immRaw = {offsBcc[11], offsBcc[11:1]};
			isSpn8:  immRaw = spn8;
			isNone:  immRaw = '0;
			default: immRaw = '0;
		endcase

		imm = {{(immW-immRawW){immRaw[immRawW-1]}}, immRaw};
		if (immSel == isLui6)
			imm[23:0] = {alu6, 12'h000};	// upper bits already carry the sign
	end

endmodule

/* hdl/rvcOpClassify.sv */
// ##################
// rvcOpClassify
// opcode match giving micro-op, format, variant, size and sub-index
// ##################

`timescale 1ns/1ps

module rvcOpClassify (
	input  rvcDecPkg::instrT instr,
	output rvcDecPkg::nmidT  nmid,
	output rvcDecPkg::fmidT  fmid,
	output rvcDecPkg::ityT   ity,
	output rvcDecPkg::btyT   bty,
	output rvcDecPkg::ucIxT  ucIx
);
	import rvcDecPkg::*;

	typedef struct packed {
		nmidT nmid;
		fmidT fmid;
		ityT  ity;
		btyT  bty;
		ucIxT ucIx;
	} decT;

	decT dec;

	always_comb begin
		dec = decT'{ucInvop, fmInv, itySb, '0, '0};

		casez (instr)
			// quadrant 0
			16'b000_zzz_zzz_zz_zzz_00: begin	// ADDI4SPN
				dec = decT'{ucAlu3, fmImm8Reg, ityUl, '0, ucIxAluAdd};
				if (instr[12:5] == 8'h00) begin
					dec.nmid = ucOpIxt;
					dec.fmid = fmZ;
					dec.ucIx = ucIxIxtBreak;
				end
			end
			16'b001_zzz_zzz_zz_zzz_00: dec = decT'{ucMovMr, fmLdRegDispReg, itySw, btySq, '0};
			16'b010_zzz_zzz_zz_zzz_00: dec = decT'{ucMovMr, fmLdRegDispReg, itySb, btySl, '0};
			16'b011_zzz_zzz_zz_zzz_00: dec = decT'{ucMovMr, fmLdRegDispReg, itySb, btySq, '0};
			16'b100_zzz_zzz_zz_zzz_00: dec = decT'{ucInvop, fmInv, itySb, '0, '0};	// reserved
			16'b101_zzz_zzz_zz_zzz_00: dec = decT'{ucMovRm, fmLdRegDispReg, ityUw, btySq, '0};
			16'b110_zzz_zzz_zz_zzz_00: dec = decT'{ucMovRm, fmLdRegDispReg, ityUb, btySl, '0};
			16'b111_zzz_zzz_zz_zzz_00: dec = decT'{ucMovRm, fmLdRegDispReg, ityUb, btySq, '0};

			// quadrant 1
			16'b000_zzz_zzz_zz_zzz_01: dec = decT'{ucAlu3, fmImm8Reg, itySb, '0, ucIxAluAdd};
			16'b001_zzz_zzz_zz_zzz_01: dec = decT'{ucAlu3, fmImm8Reg, itySb, '0, ucIxAluAddSl};
			16'b010_zzz_zzz_zz_zzz_01: dec = decT'{ucMovIr, fmImm8Reg, itySb, '0, ucIxLdiLdix};
			16'b011_zzz_zzz_zz_zzz_01: begin	// LUI
				dec = decT'{ucMovIr, fmImm8Reg, itySw, '0, ucIxLdiLdix};
				if (instr[11:7] == 5'h02)	// rd of sp means ADDI16SP
					dec = decT'{ucAlu3, fmImm8Reg, ityUb, '0, ucIxAluAdd};
			end
			16'b100_z00_zzz_zz_zzz_01: dec = decT'{ucShad3, fmImm8Reg, ityNw, '0, ucIxShadShlrQ3};
			16'b100_z01_zzz_zz_zzz_01: dec = decT'{ucShad3, fmImm8Reg, ityNw, '0, ucIxShadSharQ3};
			16'b100_z10_zzz_zz_zzz_01: dec = decT'{ucAlu3, fmImm8Reg, ityUw, '0, ucIxAluAnd};
			16'b100_011_zzz_00_zzz_01: dec = decT'{ucAlu3, fmRegReg, ityUb, '0, ucIxAluSub};
			16'b100_011_zzz_01_zzz_01: dec = decT'{ucAlu3, fmRegReg, ityUb, '0, ucIxAluXor};
			16'b100_011_zzz_10_zzz_01: dec = decT'{ucAlu3, fmRegReg, ityUb, '0, ucIxAluOr};
			16'b100_011_zzz_11_zzz_01: dec = decT'{ucAlu3, fmRegReg, ityUb, '0, ucIxAluAnd};
			16'b100_111_zzz_00_zzz_01: dec = decT'{ucAlu3, fmRegReg, ityUb, '0, ucIxAluSubSl};
			16'b100_111_zzz_01_zzz_01: dec = decT'{ucAlu3, fmRegReg, ityUb, '0, ucIxAluAddSl};
			16'b101_zzz_zzz_zz_zzz_01: dec = decT'{ucBra, fmPcDisp8, itySb, '0, '0};
			16'b110_zzz_zzz_zz_zzz_01: dec = decT'{ucJcmp, fmRegPc, ityUw, '0, ucIxJcmpQeq};
			16'b111_zzz_zzz_zz_zzz_01: dec = decT'{ucJcmp, fmRegPc, ityUw, '0, ucIxJcmpQne};

			// quadrant 2
			16'b000_zzz_zzz_zz_zzz_10: dec = decT'{ucShad3, fmImm8Reg, ityNb, '0, ucIxShadShldQ3};
			16'b001_zzz_zzz_zz_zzz_10: dec = decT'{ucMovMr, fmLdDi4SpReg, itySw, btySq, '0};
			16'b010_zzz_zzz_zz_zzz_10: dec = decT'{ucMovMr, fmLdDi4SpReg, itySb, btySl, '0};
			16'b011_zzz_zzz_zz_zzz_10: dec = decT'{ucMovMr, fmLdDi4SpReg, itySb, btySq, '0};
			16'b100_0zz_zzz_zz_zzz_10: begin	// MV, JR
				dec = decT'{ucConvRr, fmRegReg, itySw, '0, ucIxConvMov};
				if (instr[6:2] == 5'h00) begin
					dec.nmid = ucJmp;
					dec.fmid = fmReg;
					dec.ity  = itySb;
				end
			end
			16'b100_1zz_zzz_zz_zzz_10: begin	// ADD, JALR
				dec = decT'{ucAlu3, fmRegReg, itySb, '0, ucIxAluAdd};
				if (instr[6:2] == 5'h00) begin
					dec.nmid = ucJsr;
					dec.fmid = fmReg;
					dec.ity  = itySb;
				end
			end
			16'b101_zzz_zzz_zz_zzz_10: dec = decT'{ucMovRm, fmLdDi4SpReg, ityUw, btySq, '0};
			16'b110_zzz_zzz_zz_zzz_10: dec = decT'{ucMovRm, fmLdDi4SpReg, ityUb, btySl, '0};
			16'b111_zzz_zzz_zz_zzz_10: dec = decT'{ucMovRm, fmLdDi4SpReg, ityUb, btySq, '0};

			// 32-bit words are not ours
			16'bzzz_zzz_zzz_zz_zzz_11: dec = decT'{ucNop, fmZ, itySb, '0, '0};

			default: dec = decT'{ucInvop, fmInv, itySb, '0, '0};
		endcase

		// JR/JALR with no target register at all is BREAK
		if (dec.fmid == fmReg && instr[11:7] == 5'h00) begin
			dec.nmid = ucOpIxt;
			dec.fmid = fmZ;
			dec.ucIx = ucIxIxtBreak;
		end
	end

	assign nmid = dec.nmid;
	assign fmid = dec.fmid;
	assign ity  = dec.ity;
	assign bty  = dec.bty;
	assign ucIx = dec.ucIx;

endmodule

/* hdl/rvcOperandStage.sv */
// ##################
// rvcOperandStage
// per-format operand routing, immediate select and the output register
// ##################

`timescale 1ns/1ps

module rvcOperandStage (
	input  logic               clock,
	input  logic               arstN,
	input  logic               instrValid,
	input  rvcDecPkg::instrT   instr,
	input  rvcDecPkg::nmidT    nmid,
	input  rvcDecPkg::fmidT    fmid,
	input  rvcDecPkg::ityT     ity,
	input  rvcDecPkg::btyT     bty,
	input  rvcDecPkg::ucIxT    ucIx,
	output logic               outValid,
	output rvcDecPkg::gprIdT   regN,
	output rvcDecPkg::gprIdT   regM,
	output rvcDecPkg::gprIdT   regO,
	output rvcDecPkg::immT     imm,
	output rvcDecPkg::uCmdT    uCmd,
	output rvcDecPkg::uIxtT    uIxt
);
	import rvcDecPkg::*;

	gprIdT  regMDfl, regNDfl, regMEr, regNEr, regMFr, regMFpr, regNFpr;
	gprIdT  regNNext, regMNext, regONext;
	immSelT immSel;
	immT    immNext;
	uIxtT   uIxtNext;
	logic   isQw;

	rvcRegMap regMap (
		.instr  (instr),
		.regMDfl(regMDfl),
		.regNDfl(regNDfl),
		.regMEr (regMEr),
		.regNEr (regNEr),
		.regMFr (regMFr),
		.regMFpr(regMFpr),
		.regNFpr(regNFpr)
	);

	rvcImmGen immGen (
		.instr (instr),
		.immSel(immSel),
		.imm   (immNext)
	);

	assign isQw = (bty[1:0] == 2'b11);

	always_comb begin
		regNNext = regZero;
		regMNext = regZero;
		regONext = regZero;
		immSel   = isNone;
		uIxtNext = {ucScalar, ucIx};

		case (fmid)
			fmReg: begin	// JR/JALR link into regLink
				regMNext = regNDfl;
				regNNext = regLink;
			end
			fmRegReg: begin
				regMNext = (ity == itySw) ? regMDfl : regNDfl;
				regONext = (ity == itySw) ? regNDfl : regMDfl;
				regNNext = regNDfl;
				if (ity == ityUb) begin	// compressed 3-bit fields
					regMNext = regNEr;
					regONext = regMEr;
					regNNext = regNEr;
				end
			end
			fmLdRegDispReg: begin
				regMNext = regNEr;
				regONext = regImm;
				regNNext = (ity == itySw || ity == ityUw) ? regMFr : regMEr;
				immSel   = isQw ? isQw4 : isLw4;
				uIxtNext = {ucScalar, bty[1:0], 1'b0, 3'b000};
			end
			fmLdDi4SpReg: begin
				regMNext = regSp;
				regONext = regImm;
				uIxtNext = {ucScalar, bty[1:0], 1'b0, 3'b000};
				case (ity)
					itySw:   regNNext = regNFpr;
					ityUb:   regNNext = regMDfl;	// store data from rs2
					ityUw:   regNNext = regMFpr;
					default: regNNext = regNDfl;
				endcase
				if (ity == ityUb || ity == ityUw)
					immSel = isQw ? isQwSt6 : isLwSt6;
				else
					immSel = isQw ? isQwLd6 : isLwLd6;
			end
			fmImm8Reg: begin
				regMNext = regNDfl;
				regONext = regImm;
				regNNext = regNDfl;
				immSel   = isAlu6;
				case (ity)
					itySw: immSel = isLui6;
					ityUb: immSel = isA16Sp;
					ityUw: begin
						regMNext = regNEr;
						regNNext = regNEr;
					end
					ityUl: begin	// ADDI4SPN
						regMNext = regSp;
						regNNext = regMEr;
						immSel   = isSpn8;
					end
					ityNb: immSel = isAlu6Z;
					ityNw: begin
						regMNext = regNEr;
						regNNext = regNEr;
						immSel   = isAlu6Z;
					end
					default: immSel = isAlu6;
				endcase
			end
			fmRegPc: begin	// BEQZ/BNEZ compare rs1' against zero
				regMNext = regNEr;
				regONext = regZero;
				immSel   = isJcc8;
				uIxtNext = {ucScalar, ucIxBraFixed};
			end
			fmPcDisp8: begin
				regMNext = regBpc;
				regONext = regImm;
				immSel   = isJ11;
				uIxtNext = {ucScalar, ucIxBraFixed};
			end
			default: begin	// fmInv and fmZ leave everything on regZero
			end
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
			regN     <= '0;
			regM     <= '0;
			regO     <= '0;
			imm      <= '0;
			uCmd     <= '0;
			uIxt     <= '0;
		end else begin
			outValid <= instrValid;
			if (instrValid) begin	// hold last result through idle cycles
				regN <= regNNext;
				regM <= regMNext;
				regO <= regONext;
				imm  <= immNext;
				uCmd <= {ccAlways, nmid};
				uIxt <= uIxtNext;
			end
		end
	end

endmodule

/* hdl/rvcDecoder.sv */
// ##################
// rvcDecoder
// one-cycle compressed-instruction decode stage
// ##################

`timescale 1ns/1ps

module rvcDecoder (
	input  logic              clock,
	input  logic              arstN,
	input  logic              instrValid,
	input  rvcDecPkg::instrT  instr,
	output logic              outValid,
	output rvcDecPkg::gprIdT  regN,
	output rvcDecPkg::gprIdT  regM,
	output rvcDecPkg::gprIdT  regO,
	output rvcDecPkg::immT    imm,
	output rvcDecPkg::uCmdT   uCmd,
	output rvcDecPkg::uIxtT   uIxt
);
	import rvcDecPkg::*;

	nmidT nmid;
	fmidT fmid;
	ityT  ity;
	btyT  bty;
	ucIxT ucIx;

	rvcOpClassify classify (
		.instr(instr),
		.nmid (nmid),
		.fmid (fmid),
		.ity  (ity),
		.bty  (bty),
		.ucIx (ucIx)
	);

	rvcOperandStage operands (
		.clock     (clock),
		.arstN     (arstN),
		.instrValid(instrValid),
		.instr     (instr),
		.nmid      (nmid),
		.fmid      (fmid),
		.ity       (ity),
		.bty       (bty),
		.ucIx      (ucIx),
		.outValid  (outValid),
		.regN      (regN),
		.regM      (regM),
		.regO      (regO),
		.imm       (imm),
		.uCmd      (uCmd),
		.uIxt      (uIxt)
	);

endmodule

/* testbench/rvcDecoderTb.sv */
// ####################
// rvcDecoderTb
// drives directed and random compressed words through the decode stage
// and checks every result against a rule-based model
// ####################

`timescale 1ns/1ps

module rvcDecoderTb;
	import rvcDecPkg::*;

	localparam int clkPeriod = 4;
	localparam int numDirected = 44;
	localparam int numRandom = 300;
	localparam int watchdogCycles = numDirected + numRandom + 40;	// reset, idles, margin

	// low half of the 5-bit register space, x8..x15 doubles as the 3-bit map
	localparam gprIdT lowTable [16] = '{regZero, regLink, regSp, regGbr, r4, r5, regDlr, r7,
		r8, r9, r10, r11, r12, r13, r2, r3};

	localparam instrT directed [numDirected] = '{
		// memory, register-relative then sp-relative
		16'b010_000_010_10_001_00, 16'b011_111_110_11_111_00, 16'b110_101_001_01_011_00,
		16'b111_010_100_10_101_00, 16'b001_110_011_01_010_00, 16'b101_001_111_10_000_00,
		16'b010_1_00101_10110_10, 16'b011_0_10100_01111_10, 16'b001_1_00011_11010_10,
		16'b110_101101_11110_10, 16'b111_011010_00110_10, 16'b101_110011_10001_10,
		// immediate ALU forms
		16'b000_1_01100_11101_01, 16'b001_0_11001_00111_01, 16'b010_1_00001_00000_01,
		16'b011_1_00110_10101_01, 16'b011_0_11111_01010_01, 16'b011_1_00010_10110_01,
		16'b000_10110101_011_00, 16'b100_1_00_011_10101_01, 16'b100_0_01_110_00011_01,
		16'b100_1_10_101_11100_01, 16'b000_1_01110_00101_10,
		// register-register, one reserved slot
		16'b100_0_11_000_00_111_01, 16'b100_0_11_011_01_110_01, 16'b100_0_11_101_10_001_01,
		16'b100_0_11_110_11_010_01, 16'b100_1_11_100_00_011_01, 16'b100_1_11_111_01_100_01,
		16'b100_1_11_001_10_010_01, 16'b100_0_00011_00110_10, 16'b100_1_10001_01001_10,
		// control flow and the BREAK aliases
		16'b101_01101101101_01, 16'b101_10010011011_01, 16'b110_101_010_10110_01,
		16'b111_110_111_01001_01, 16'b100_0_00001_00000_10, 16'b100_1_10110_00000_10,
		16'b100_1_00000_00000_10, 16'b100_0_00000_00000_10, 16'h0000,
		// reserved quadrant 0 and 32-bit words
		16'b100_101_011_01_110_00, 16'h3A57, 16'hFFFF
	};

	logic  clock;
	logic  arstN;
	logic  instrValid;
	instrT instr;
	logic  outValid;
	gprIdT regN;
	gprIdT regM;
	gprIdT regO;
	immT   imm;
	uCmdT  uCmd;
	uIxtT  uIxt;

	// model output for the word currently driven
	gprIdT nxtN;
	gprIdT nxtM;
	gprIdT nxtO;
	immT   nxtImm;
	nmidT  nxtCmd;
	ucIxT  nxtSub;

	// expected slot, one cycle behind the inputs
	logic  expValid;
	gprIdT expN;
	gprIdT expM;
	gprIdT expO;
	immT   expImm;
	uCmdT  expCmd;
	uIxtT  expIxt;

	int     checkedCount;
	integer seed;

	rvcDecoder UUT (
		.clock     (clock),
		.arstN     (arstN),
		.instrValid(instrValid),
		.instr     (instr),
		.outValid  (outValid),
		.regN      (regN),
		.regM      (regM),
		.regO      (regO),
		.imm       (imm),
		.uCmd      (uCmd),
		.uIxt      (uIxt)
	);

	initial begin
		clock = 1'b0;
		forever #(clkPeriod / 2) clock = ~clock;
	end

	function automatic gprIdT fullReg(input logic [4:0] f);
		fullReg = f[4] ? {2'b00, f} : lowTable[f[3:0]];
	endfunction

	function automatic gprIdT shortReg(input logic [2:0] f);
		shortReg = lowTable[{1'b1, f}];
	endfunction

	function automatic gprIdT fpReg(input logic [4:0] n);
		fpReg = fpBase + {2'b00, n};
	endfunction

	function automatic immT sext12(input logic [11:0] v);
		sext12 = {{21{v[11]}}, v};
	endfunction

	task automatic predict(input instrT w);
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic [4:0]  rs2;
		logic [2:0]  rdS;
		logic [2:0]  rs2S;
		logic [5:0]  imm6;
		logic [11:0] off;
		f3 = w[15:13];
		rd = w[11:7];
		rs2 = w[6:2];
		rdS = w[9:7];
		rs2S = w[4:2];
		imm6 = {w[12], w[6:2]};
		off = '0;
		nxtN = regZero;
		nxtM = regZero;
		nxtO = regZero;
		nxtImm = '0;
		nxtCmd = ucInvop;
		nxtSub = '0;
		case (w[1:0])
			2'b00: begin
				if (f3 == 3'd0 && w[12:5] == 8'h00) begin
					nxtCmd = ucOpIxt;
					nxtSub = ucIxIxtBreak;
				end else if (f3 == 3'd0) begin	// ADDI4SPN
					off[9:6] = w[10:7];
					off[5:4] = w[12:11];
					off[3] = w[5];
					off[2] = w[6];
					nxtCmd = ucAlu3;
					nxtN = shortReg(rs2S);
					nxtM = regSp;
					nxtO = regImm;
					nxtImm = sext12(off);
				end else if (f3 != 3'd4) begin	// f3 of 4 stays invalid
					nxtCmd = f3[2] ? ucMovRm : ucMovMr;
					nxtM = shortReg(rdS);
					nxtO = regImm;
					nxtN = (f3[1:0] == 2'b01) ? fpReg({2'b01, rs2S}) : shortReg(rs2S);
					off[5:3] = w[12:10];
					if (f3[1:0] == 2'b10) begin	// word access
						off[2] = w[6];
						off[6] = w[5];
						nxtSub = {btySl[1:0], 4'h0};
					end else begin
						off[7:6] = w[6:5];
						nxtSub = {btySq[1:0], 4'h0};
					end
					nxtImm = sext12(off);
				end
			end
			2'b01: begin
				nxtM = fullReg(rd);
				nxtN = fullReg(rd);
				nxtO = regImm;
				nxtImm = sext12({{6{w[12]}}, imm6});
				case (f3)
					3'd0: nxtCmd = ucAlu3;
					3'd1: begin
						nxtCmd = ucAlu3;
						nxtSub = ucIxAluAddSl;
					end
					3'd2: begin
						nxtCmd = ucMovIr;
						nxtSub = ucIxLdiLdix;
					end
					3'd3: begin
						if (rd == 5'd2) begin	// ADDI16SP
							off[11:9] = {3{w[12]}};
							off[8:7] = w[4:3];
							off[6] = w[5];
							off[5] = w[2];
							off[4] = w[6];
							nxtCmd = ucAlu3;
							nxtImm = sext12(off);
						end else begin
							nxtCmd = ucMovIr;
							nxtSub = ucIxLdiLdix;
							nxtImm = {{15{w[12]}}, imm6, 12'h000};
						end
					end
					3'd4: begin
						nxtM = shortReg(rdS);
						nxtN = shortReg(rdS);
						case (w[11:10])
							2'b00: begin
								nxtCmd = ucShad3;
								nxtSub = ucIxShadShlrQ3;
								nxtImm = {27'b0, imm6};	// shift amounts are unsigned
							end
							2'b01: begin
								nxtCmd = ucShad3;
								nxtSub = ucIxShadSharQ3;
								nxtImm = {27'b0, imm6};
							end
							2'b10: begin
								nxtCmd = ucAlu3;
								nxtSub = ucIxAluAnd;
							end
							default: begin
								nxtO = shortReg(rs2S);
								nxtImm = '0;
								nxtCmd = ucAlu3;
								case ({w[12], w[6:5]})
									3'b000: nxtSub = ucIxAluSub;
									3'b001: nxtSub = ucIxAluXor;
									3'b010: nxtSub = ucIxAluOr;
									3'b011: nxtSub = ucIxAluAnd;
									3'b100: nxtSub = ucIxAluSubSl;
									3'b101: nxtSub = ucIxAluAddSl;
									default: begin	// reserved
										nxtCmd = ucInvop;
										nxtN = regZero;
										nxtM = regZero;
										nxtO = regZero;
									end
								endcase
							end
						endcase
					end
					3'd5: begin	// J, offset counted in halfwords
						off[11] = w[12];
						off[10] = w[8];
						off[9:8] = w[10:9];
						off[7] = w[6];
						off[6] = w[7];
						off[5] = w[2];
						off[4] = w[11];
						off[3:1] = w[5:3];
						nxtCmd = ucBra;
						nxtN = regZero;
						nxtM = regBpc;
						nxtSub = ucIxBraFixed;
						nxtImm = sext12({off[11], off[11:1]});
					end
					default: begin	// BEQZ, BNEZ
						off[11:8] = {4{w[12]}};
						off[7:6] = w[6:5];
						off[5] = w[2];
						off[4:3] = w[11:10];
						off[2:1] = w[4:3];
						nxtCmd = ucJcmp;
						nxtN = regZero;
						nxtM = shortReg(rdS);
						nxtO = regZero;
						nxtSub = ucIxBraFixed;
						nxtImm = sext12({off[11], off[11:1]});
					end
				endcase
			end
			2'b10: begin
				if (f3 == 3'd0) begin	// SLLI
					nxtCmd = ucShad3;
					nxtSub = ucIxShadShldQ3;
					nxtM = fullReg(rd);
					nxtN = fullReg(rd);
					nxtO = regImm;
					nxtImm = {27'b0, imm6};
				end else if (f3 == 3'd4 && rs2 != 5'd0) begin
					nxtCmd = w[12] ? ucAlu3 : ucConvRr;
					nxtN = fullReg(rd);
					nxtM = w[12] ? fullReg(rd) : fullReg(rs2);
					nxtO = w[12] ? fullReg(rs2) : fullReg(rd);
				end else if (f3 == 3'd4 && rd != 5'd0) begin	// JR, JALR
					nxtCmd = w[12] ? ucJsr : ucJmp;
					nxtSub = w[12] ? ucIxAluAdd : ucIxConvMov;
					nxtM = fullReg(rd);
					nxtN = regLink;
				end else if (f3 == 3'd4) begin
					nxtCmd = ucOpIxt;
					nxtSub = ucIxIxtBreak;
				end else if (!f3[2]) begin	// loads from sp
					nxtCmd = ucMovMr;
					nxtM = regSp;
					nxtO = regImm;
					nxtN = (f3 == 3'd1) ? fpReg(rd) : fullReg(rd);
					off[5] = w[12];
					if (f3 == 3'd2) begin
						off[4:2] = w[6:4];
						off[7:6] = w[3:2];
						nxtSub = {btySl[1:0], 4'h0};
					end else begin
						off[4:3] = w[6:5];
						off[8:6] = w[4:2];
						nxtSub = {btySq[1:0], 4'h0};
					end
					nxtImm = sext12(off);
				end else begin	// stores to sp
					nxtCmd = ucMovRm;
					nxtM = regSp;
					nxtO = regImm;
					nxtN = (f3 == 3'd5) ? fpReg(rs2) : fullReg(rs2);
					if (f3 == 3'd6) begin
						off[5:2] = w[12:9];
						off[7:6] = w[8:7];
						nxtSub = {btySl[1:0], 4'h0};
					end else begin
						off[5:3] = w[12:10];
						off[8:6] = w[9:7];
						nxtSub = {btySq[1:0], 4'h0};
					end
					nxtImm = sext12(off);
				end
			end
			default: nxtCmd = ucNop;	// 32-bit encodings pass as NOP
		endcase
	endtask

	task automatic send(input instrT w);
		instr = w;
		instrValid = 1'b1;
		predict(w);
		@(posedge clock);
		#1;
	endtask

	task automatic idleCycle();
		instrValid = 1'b0;
		@(posedge clock);
		#1;
	endtask

	task automatic reportMismatch(input string name, input logic [32:0] expV,
		input logic [32:0] actV);
		$display("FAILED %s expected %h actual %h", name, expV, actV);
		$display("Simulation failed");
		$fatal(1, "output mismatch");
	endtask

	always @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			expValid <= 1'b0;
			expN     <= '0;
			expM     <= '0;
			expO     <= '0;
			expImm   <= '0;
			expCmd   <= '0;
			expIxt   <= '0;
		end else begin
			expValid <= instrValid;
			if (instrValid) begin	// outputs hold while idle
				expN   <= nxtN;
				expM   <= nxtM;
				expO   <= nxtO;
				expImm <= nxtImm;
				expCmd <= {ccAlways, nxtCmd};
				expIxt <= {ucScalar, nxtSub};
			end
		end
	end

	always @(posedge clock) begin
		if (arstN && outValid)
			checkedCount <= checkedCount + 1;
	end

	validCheck: assert property (@(posedge clock) disable iff (!arstN) outValid == expValid)
		else reportMismatch("outValid", {32'b0, $sampled(expValid)},
			{32'b0, $sampled(outValid)});
	regNCheck: assert property (@(posedge clock) disable iff (!arstN) regN == expN)
		else reportMismatch("regN", {26'b0, $sampled(expN)}, {26'b0, $sampled(regN)});
	regMCheck: assert property (@(posedge clock) disable iff (!arstN) regM == expM)
		else reportMismatch("regM", {26'b0, $sampled(expM)}, {26'b0, $sampled(regM)});
	regOCheck: assert property (@(posedge clock) disable iff (!arstN) regO == expO)
		else reportMismatch("regO", {26'b0, $sampled(expO)}, {26'b0, $sampled(regO)});
	immCheck: assert property (@(posedge clock) disable iff (!arstN) imm == expImm)
		else reportMismatch("imm", $sampled(expImm), $sampled(imm));
	uCmdCheck: assert property (@(posedge clock) disable iff (!arstN) uCmd == expCmd)
		else reportMismatch("uCmd", {24'b0, $sampled(expCmd)}, {24'b0, $sampled(uCmd)});
	uIxtCheck: assert property (@(posedge clock) disable iff (!arstN) uIxt == expIxt)
		else reportMismatch("uIxt", {24'b0, $sampled(expIxt)}, {24'b0, $sampled(uIxt)});

	initial begin
		#(watchdogCycles * clkPeriod);
		$display("watchdog expired before the instruction stream finished");
		$display("Simulation failed");
		$fatal(1, "timeout");
	end

	initial begin
		logic [31:0] rnd;
		seed = 95770;
		checkedCount = 0;
		arstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		nxtN = regZero;
		nxtM = regZero;
		nxtO = regZero;
		nxtImm = '0;
		nxtCmd = ucInvop;
		nxtSub = '0;
		repeat (2) @(posedge clock);
		#1;
		arstN = 1'b1;
		idleCycle();	// nothing valid yet
		for (int i = 0; i < numDirected; i++) begin
			if (i == 12 || i == 41)
				idleCycle();	// gap in the stream, outValid must drop
			send(directed[i]);
		end
		idleCycle();
		for (int i = 0; i < numRandom; i++) begin
			rnd = $random(seed);
			send(rnd[15:0]);
		end
		idleCycle();
		idleCycle();
		if (checkedCount == numDirected + numRandom) begin
			$display("Simulation passed");
			$finish;
		end else begin
			$display("%0d results seen for %0d instructions sent", checkedCount,
				numDirected + numRandom);
			$display("Simulation failed");
			$fatal(1, "result count mismatch");
		end
	end

endmodule

/* rvcDecoder.f */
hdl/rvcDecPkg.sv
hdl/rvcRegMap.sv
hdl/rvcImmGen.sv
hdl/rvcOpClassify.sv
hdl/rvcOperandStage.sv
hdl/rvcDecoder.sv
testbench/rvcDecoderTb.sv

/* run.sh */
#!/bin/sh
# build the decode stage testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f rvcDecoder.f --top-module rvcDecoderTb -o rvcDecoderSim &&
./obj_dir/rvcDecoderSim || exit 1
